/* vga_timing_pkg.sv */
`default_nettype none

package vga_timing_pkg;

    // Row or column position within the full scan.
    typedef logic [10:0] coord_t;

    // Default scan, 160 by 120 with short porches.
    localparam int DEF_H_ACTIVE = 160;
    localparam int DEF_H_FRONT  = 4;
    localparam int DEF_H_SYNC   = 12;
    localparam int DEF_H_BACK   = 8;

    localparam int DEF_V_ACTIVE = 120;
    localparam int DEF_V_FRONT  = 2;
    localparam int DEF_V_SYNC   = 2;
    localparam int DEF_V_BACK   = 4;

    // Clocks per pixel.
    localparam int DEF_PIX_DIV = 4;

endpackage

`default_nettype wire

/* fb_bus_pkg.sv */
`default_nettype none

package fb_bus_pkg;

    typedef logic [31:0] addr_t;

    // One RGB332 pixel, red in the top three bits.
    typedef logic [7:0] pixel_t;

    // A fetched halfword, written whole and shown as two pixels, high byte first.
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            pixel_t hi;
            pixel_t lo;
        } pix;
    } pixel_pair_t;

    typedef enum logic [2:0] {
        FETCH_IDLE         = 3'd0,
        FETCH_PRESENT_ADDR = 3'd1,
        FETCH_WAIT         = 3'd2,
        FETCH_READ_DATA    = 3'd3,
        FETCH_FINISH       = 3'd4
    } fetch_state_t;

    localparam addr_t DEF_BASE_ADDR = 32'h0000_1050;

endpackage

`default_nettype wire

/* vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = vga_timing_pkg::DEF_H_ACTIVE,
    parameter int H_FRONT  = vga_timing_pkg::DEF_H_FRONT,
    parameter int H_SYNC   = vga_timing_pkg::DEF_H_SYNC,
    parameter int H_BACK   = vga_timing_pkg::DEF_H_BACK,
    parameter int V_ACTIVE = vga_timing_pkg::DEF_V_ACTIVE,
    parameter int V_FRONT  = vga_timing_pkg::DEF_V_FRONT,
    parameter int V_SYNC   = vga_timing_pkg::DEF_V_SYNC,
    parameter int V_BACK   = vga_timing_pkg::DEF_V_BACK,
    parameter int PIX_DIV  = vga_timing_pkg::DEF_PIX_DIV
) (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   pix_stb,
    output logic                   hsync_n,
    output logic                   vsync_n,
    output logic                   active,
    output logic                   frame_start,
    output vga_timing_pkg::coord_t row,
    output vga_timing_pkg::coord_t col
);
    import vga_timing_pkg::*;

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int DIV_W        = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    coord_t           hcount;
    coord_t           vcount;
    coord_t           h_next;
    coord_t           v_next;
    logic             line_end;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            pix_stb <= 1'b0;
        end else begin
            pix_stb <= (div_cnt == DIV_W'(PIX_DIV - 1));
            div_cnt <= (div_cnt == DIV_W'(PIX_DIV - 1)) ? '0 : div_cnt + 1'b1;
        end
    end

    assign line_end = (hcount == coord_t'(H_TOTAL - 1));
    assign h_next   = line_end ? '0 : hcount + 1'b1;

    always_comb begin
        v_next = vcount;
        if (line_end) begin
            v_next = (vcount == coord_t'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
        end
    end

    // The scan leaves reset at the top of the vertical front porch.
    always_ff @(posedge clk) begin
        if (reset) begin
            hcount      <= '0;
            vcount      <= coord_t'(V_ACTIVE);
            active      <= 1'b0;
            hsync_n     <= 1'b1;
            vsync_n     <= 1'b1;
            frame_start <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            if (pix_stb) begin
                hcount      <= h_next;
                vcount      <= v_next;
                active      <= (h_next < coord_t'(H_ACTIVE)) && (v_next < coord_t'(V_ACTIVE));
                hsync_n     <= !((h_next >= coord_t'(H_SYNC_START)) &&
                                 (h_next < coord_t'(H_SYNC_START + H_SYNC)));
                vsync_n     <= !((v_next >= coord_t'(V_SYNC_START)) &&
                                 (v_next < coord_t'(V_SYNC_START + V_SYNC)));
                frame_start <= line_end && (v_next == coord_t'(V_SYNC_START));
            end
        end
    end

    assign row = vcount;
    assign col = hcount;

endmodule

`default_nettype wire

/* fb_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_fetch #(
    parameter int                H_ACTIVE  = vga_timing_pkg::DEF_H_ACTIVE,
    parameter int                V_ACTIVE  = vga_timing_pkg::DEF_V_ACTIVE,
    parameter int                PIX_DIV   = vga_timing_pkg::DEF_PIX_DIV,
    parameter fb_bus_pkg::addr_t BASE_ADDR = fb_bus_pkg::DEF_BASE_ADDR
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pix_stb,
    input  logic                    active,
    input  logic                    frame_start,
    input  logic                    bus_ack,
    input  logic                    bus_wait,
    input  logic [15:0]             bus_data,
    output logic                    bus_req,
    output fb_bus_pkg::addr_t       bus_addr,
    output logic                    buf_we,
    output logic                    buf_sel,
    output fb_bus_pkg::pixel_pair_t wdata,
    output logic                    rd_sel,
    output logic                    byte_sel
);
    import fb_bus_pkg::*;

    localparam int PIX_TOTAL        = H_ACTIVE * V_ACTIVE;
    localparam int WORDS            = PIX_TOTAL / 2;
    localparam int CNT_W            = $clog2(PIX_TOTAL + 1);
    localparam int CMP_W            = CNT_W + 1;
    localparam int MIN_FETCH_CLOCKS = 5;

    logic [CNT_W-1:0] pix_cnt;
    logic [CNT_W-1:0] word_cnt;
    logic [CNT_W-1:0] disp_word;
    logic             armed;
    logic             fetch_ok;
    fetch_state_t     state;
    fetch_state_t     state_next;

    // A word has to arrive within the two pixels of the word shown before it.
    if (2 * PIX_DIV < MIN_FETCH_CLOCKS) begin : g_budget_check
        $error("fb_fetch: PIX_DIV is too small for one bus fetch per word");
    end

    always_ff @(posedge clk) begin
        if (reset || frame_start) begin
            pix_cnt <= '0;
        end else if (pix_stb && active) begin
            pix_cnt <= pix_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || frame_start) begin
            word_cnt <= '0;
        end else if (state == FETCH_FINISH) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // No fetch until the first frame boundary after reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            armed <= 1'b0;
        end else if (frame_start) begin
            armed <= 1'b1;
        end
    end

    assign disp_word = pix_cnt >> 1;

    // Stay at most one word ahead of the word on screen.
    assign fetch_ok = armed &&
                      (CMP_W'(word_cnt) < CMP_W'(disp_word) + CMP_W'(2)) &&
                      (word_cnt < CNT_W'(WORDS));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            FETCH_IDLE: begin
                state_next = (fetch_ok && bus_ack) ? FETCH_PRESENT_ADDR : FETCH_IDLE;
            end
            FETCH_PRESENT_ADDR: begin
                state_next = FETCH_WAIT;
            end
            FETCH_WAIT: begin
                state_next = bus_wait ? FETCH_WAIT : FETCH_READ_DATA;
            end
            FETCH_READ_DATA: begin
                state_next = FETCH_FINISH;
            end
            default: begin
                state_next = FETCH_IDLE;
            end
        endcase
    end

    assign bus_req  = (state == FETCH_IDLE) ? fetch_ok :
                      (state == FETCH_PRESENT_ADDR) || (state == FETCH_WAIT) ||
                      (state == FETCH_READ_DATA);
    assign bus_addr = BASE_ADDR + addr_t'(word_cnt);

    // The word lands in the buffer that is not on screen.
    assign buf_we    = (state == FETCH_READ_DATA);
    assign buf_sel   = word_cnt[0];
    assign wdata.raw = bus_data;

    // Even pixels take the high byte.
    assign rd_sel   = disp_word[0];
    assign byte_sel = ~pix_cnt[0];

endmodule

`default_nettype wire

/* pixel_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    buf_we,
    input  logic                    buf_sel,
    input  fb_bus_pkg::pixel_pair_t wdata,
    input  logic                    rd_sel,
    input  logic                    byte_sel,
    input  logic                    active,
    input  logic                    hsync_n,
    input  logic                    vsync_n,
    output fb_bus_pkg::pixel_t      rgb,
    output logic                    hsync,
    output logic                    vsync
);
    import fb_bus_pkg::*;

    pixel_pair_t words [2];
    pixel_pair_t cur_word;
    pixel_t      cur_pix;

    always_ff @(posedge clk) begin
        if (buf_we) begin
            words[buf_sel].raw <= wdata.raw;
        end
    end

    assign cur_word = words[rd_sel];
    assign cur_pix  = byte_sel ? cur_word.pix.hi : cur_word.pix.lo;

    // Syncs take the same single register stage as the colour.
    always_ff @(posedge clk) begin
        if (reset) begin
            rgb   <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            rgb   <= active ? cur_pix : '0;
            hsync <= hsync_n;
            vsync <= vsync_n;
        end
    end

endmodule

`default_nettype wire

/* vga_fb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_fb_top #(
    parameter int                H_ACTIVE  = vga_timing_pkg::DEF_H_ACTIVE,
    parameter int                H_FRONT   = vga_timing_pkg::DEF_H_FRONT,
    parameter int                H_SYNC    = vga_timing_pkg::DEF_H_SYNC,
    parameter int                H_BACK    = vga_timing_pkg::DEF_H_BACK,
    parameter int                V_ACTIVE  = vga_timing_pkg::DEF_V_ACTIVE,
    parameter int                V_FRONT   = vga_timing_pkg::DEF_V_FRONT,
    parameter int                V_SYNC    = vga_timing_pkg::DEF_V_SYNC,
    parameter int                V_BACK    = vga_timing_pkg::DEF_V_BACK,
    parameter int                PIX_DIV   = vga_timing_pkg::DEF_PIX_DIV,
    parameter fb_bus_pkg::addr_t BASE_ADDR = fb_bus_pkg::DEF_BASE_ADDR
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               bus_ack,
    input  logic               bus_wait,
    input  logic [15:0]        bus_data,
    output logic               bus_req,
    output fb_bus_pkg::addr_t  bus_addr,
    output fb_bus_pkg::pixel_t rgb,
    output logic               hsync,
    output logic               vsync
);
    import fb_bus_pkg::*;

    logic        pix_stb;
    logic        active;
    logic        frame_start;
    logic        hsync_n;
    logic        vsync_n;
    logic        buf_we;
    logic        buf_sel;
    logic        rd_sel;
    logic        byte_sel;
    pixel_pair_t wdata;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .PIX_DIV(PIX_DIV)
    ) u_timing (
        .clk(clk), .reset(reset), .pix_stb(pix_stb), .hsync_n(hsync_n),
        .vsync_n(vsync_n), .active(active), .frame_start(frame_start),
        .row(), .col()
    );

    fb_fetch #(
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .PIX_DIV(PIX_DIV), .BASE_ADDR(BASE_ADDR)
    ) u_fetch (
        .clk(clk), .reset(reset), .pix_stb(pix_stb), .active(active),
        .frame_start(frame_start), .bus_ack(bus_ack), .bus_wait(bus_wait),
        .bus_data(bus_data), .bus_req(bus_req), .bus_addr(bus_addr),
        .buf_we(buf_we), .buf_sel(buf_sel), .wdata(wdata),
        .rd_sel(rd_sel), .byte_sel(byte_sel)
    );

    pixel_buffer u_buffer (
        .clk(clk), .reset(reset), .buf_we(buf_we), .buf_sel(buf_sel), .wdata(wdata),
        .rd_sel(rd_sel), .byte_sel(byte_sel), .active(active), .hsync_n(hsync_n),
        .vsync_n(vsync_n), .rgb(rgb), .hsync(hsync), .vsync(vsync)
    );

endmodule

`default_nettype wire

/* vga_fb_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_fb_sva (
    input logic                     clk,
    input logic                     reset,
    input fb_bus_pkg::fetch_state_t state,
    input logic                     bus_req,
    input fb_bus_pkg::addr_t        bus_addr,
    input logic                     active,
    input logic                     buf_we,
    input logic                     buf_sel,
    input logic                     rd_sel
);
    import fb_bus_pkg::*;

    // Once raised, the request is held until the fetch reaches finish.
    req_held: assert property (@(posedge clk) disable iff (reset)
        $fell(bus_req) |-> (state == FETCH_FINISH))
        else $error("bus_req dropped before the fetch finished");

    // Address is set up in present-address and held to finish.
    addr_stable: assert property (@(posedge clk) disable iff (reset)
        (state == FETCH_WAIT || state == FETCH_READ_DATA || state == FETCH_FINISH)
        |-> $stable(bus_addr))
        else $error("bus_addr changed during a fetch");

    no_overwrite: assert property (@(posedge clk) disable iff (reset)
        (buf_we && active) |-> (buf_sel != rd_sel))
        else $error("buffer write hit the word on screen");

endmodule

bind fb_fetch vga_fb_sva u_sva (
    .clk(clk), .reset(reset), .state(state), .bus_req(bus_req), .bus_addr(bus_addr),
    .active(active), .buf_we(buf_we), .buf_sel(buf_sel), .rd_sel(rd_sel)
);

`default_nettype wire

/* tb_vga_fb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vga_fb;
    import fb_bus_pkg::*;

    localparam int    H_ACTIVE = 16;
    localparam int    H_FRONT  = 2;
    localparam int    H_SYNC   = 4;
    localparam int    H_BACK   = 2;
    localparam int    V_ACTIVE = 4;
    localparam int    V_FRONT  = 1;
    localparam int    V_SYNC   = 2;
    localparam int    V_BACK   = 1;
    localparam int    PIX_DIV  = 4;
    localparam addr_t BASE_ADDR = DEF_BASE_ADDR;

    localparam int H_TOTAL        = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL        = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int WORDS          = H_ACTIVE * V_ACTIVE / 2;
    localparam int LINE_CLKS      = H_TOTAL * PIX_DIV;
    localparam int FRAME_CLKS     = LINE_CLKS * V_TOTAL;
    localparam int CLK_PERIOD     = 40;
    localparam int FRAMES_CHECKED = 2;

    localparam int T_RESET = 0;
    localparam int T_SYNC  = 1;
    localparam int T_ADDR  = 2;
    localparam int T_PIXEL = 3;
    localparam int T_BLANK = 4;

    logic        clk;
    logic        reset;
    logic        bus_ack;
    logic        bus_wait;
    logic [15:0] bus_data;
    logic        bus_req;
    addr_t       bus_addr;
    pixel_t      rgb;
    logic        hsync;
    logic        vsync;

    logic [15:0] frame_mem [WORDS];
    int          errors [5];
    int          pass_count;
    int          fail_count;
    bit          mem_ready;
    bit          locked;
    int          frames_done;
    int          fetch_idx;
    int          cyc;
    int          h_fall_cyc;
    int          v_fall_cyc;
    bit          h_fall_seen;
    bit          v_fall_seen;
    logic        prev_hsync;
    logic        prev_vsync;
    int          mh;
    int          mv;
    int          mph;

    vga_fb_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .PIX_DIV(PIX_DIV), .BASE_ADDR(BASE_ADDR)
    ) UUT (
        .clk(clk), .reset(reset), .bus_ack(bus_ack), .bus_wait(bus_wait),
        .bus_data(bus_data), .bus_req(bus_req), .bus_addr(bus_addr),
        .rgb(rgb), .hsync(hsync), .vsync(vsync)
    );

    task automatic compare_values(input int test_id, input logic [31:0] got,
                                  input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s (got 0x%0h, expected 0x%0h)",
                     $time, msg, got, exp);
            errors[test_id]++;
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_test(input int test_id, input string name);
        $display("Test %-14s %s (%0d failed checks)", name,
                 (errors[test_id] == 0) ? "PASS" : "FAIL", errors[test_id]);
    endtask

    // Expected colour at the model position, high byte of each word first.
    task automatic check_pixel();
        int          idx;
        logic [15:0] word;
        pixel_t      exp_pix;
        if (mh < H_ACTIVE && mv < V_ACTIVE) begin
            idx     = mv * H_ACTIVE + mh;
            word    = frame_mem[idx / 2];
            exp_pix = (idx % 2 == 0) ? word[15:8] : word[7:0];
            compare_values(T_PIXEL, 32'(rgb), 32'(exp_pix),
                           $sformatf("pixel at column %0d row %0d", mh, mv));
        end else begin
            compare_values(T_BLANK, 32'(rgb), 32'd0, "rgb outside the active area");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Memory slave with a random ack delay and random wait states.
    initial begin : memory_model
        int ack_delay;
        int wait_cycles;
        int word_idx;
        bus_ack  = 1'b0;
        bus_wait = 1'b0;
        bus_data = '0;
        wait (mem_ready);
        forever begin
            @(posedge clk);
            #1;
            if (bus_req) begin
                ack_delay   = $urandom_range(1, 0);
                wait_cycles = $urandom_range(2, 0);
                repeat (ack_delay) begin
                    @(posedge clk);
                    #1;
                end
                bus_ack = 1'b1;
                @(posedge clk);
                #1;
                bus_ack = 1'b0;
                compare_values(T_ADDR, bus_addr, BASE_ADDR + addr_t'(fetch_idx),
                               $sformatf("address of fetch %0d", fetch_idx));
                word_idx = int'(bus_addr - BASE_ADDR);
                if (word_idx >= 0 && word_idx < WORDS) begin
                    bus_data = frame_mem[word_idx];
                end else begin
                    $display("Memory read outside the frame at address 0x%0h", bus_addr);
                    errors[T_ADDR]++;
                    fail_count++;
                    bus_data = '0;
                end
                fetch_idx++;
                @(posedge clk);
                #1;
                repeat (wait_cycles) begin
                    bus_wait = 1'b1;
                    @(posedge clk);
                    #1;
                end
                bus_wait = 1'b0;
                while (bus_req) begin
                    @(posedge clk);
                    #1;
                end
                // Stale data after the fetch shows up as a pixel error.
                bus_data = 16'($urandom);
            end
        end
    end

    // Scan model, locked to the falling edge of vsync.
    always @(negedge clk) begin
        if (!reset && mem_ready) begin
            cyc++;
            if (locked) begin
                mph++;
                if (mph == PIX_DIV) begin
                    mph = 0;
                    mh++;
                    if (mh == H_TOTAL) begin
                        mh = 0;
                        mv = (mv == V_TOTAL - 1) ? 0 : mv + 1;
                    end
                end
            end
            if (prev_hsync && !hsync) begin
                if (h_fall_seen)
                    compare_values(T_SYNC, 32'(cyc - h_fall_cyc), 32'(LINE_CLKS), "hsync period");
                h_fall_seen = 1'b1;
                h_fall_cyc  = cyc;
            end
            if (!prev_hsync && hsync && h_fall_seen)
                compare_values(T_SYNC, 32'(cyc - h_fall_cyc), 32'(H_SYNC * PIX_DIV),
                               "hsync pulse width");
            if (!prev_vsync && vsync && v_fall_seen)
                compare_values(T_SYNC, 32'(cyc - v_fall_cyc), 32'(V_SYNC * LINE_CLKS),
                               "vsync pulse width");
            if (prev_vsync && !vsync) begin
                if (v_fall_seen) begin
                    compare_values(T_SYNC, 32'(cyc - v_fall_cyc), 32'(FRAME_CLKS), "vsync period");
                    compare_values(T_ADDR, 32'(fetch_idx), 32'(WORDS), "fetches in one frame");
                    frames_done++;
                end else begin
                    compare_values(T_ADDR, 32'(fetch_idx), 32'd0, "fetches before first vsync");
                end
                v_fall_seen = 1'b1;
                v_fall_cyc  = cyc;
                locked      = 1'b1;
                fetch_idx   = 0;
                mh          = 0;
                mv          = V_ACTIVE + V_FRONT;
                mph         = 0;
            end
            if (locked && frames_done < FRAMES_CHECKED)
                check_pixel();
            prev_hsync = hsync;
            prev_vsync = vsync;
        end
    end

    initial begin
        reset      = 1'b1;
        prev_hsync = 1'b1;
        prev_vsync = 1'b1;
        void'($urandom(32'h7778));
        for (int i = 0; i < WORDS; i++) begin
            frame_mem[i] = 16'($urandom);
        end
        mem_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        compare_values(T_RESET, 32'(bus_req), 32'd0, "bus_req in reset");
        compare_values(T_RESET, 32'(rgb), 32'd0, "rgb in reset");
        compare_values(T_RESET, 32'(hsync), 32'd1, "hsync in reset");
        compare_values(T_RESET, 32'(vsync), 32'd1, "vsync in reset");
        reset = 1'b0;
        report_test(T_RESET, "reset");
        wait (frames_done == FRAMES_CHECKED);
        report_test(T_SYNC, "sync geometry");
        report_test(T_ADDR, "bus addresses");
        report_test(T_PIXEL, "pixel data");
        report_test(T_BLANK, "blanking");
        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Three frames cover the lead-in to the first vsync and both checked frames.
    initial begin
        #((3 * FRAME_CLKS + 200) * CLK_PERIOD);
        $display("Timeout: the scan did not finish %0d frames in time", FRAMES_CHECKED);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
vga_timing_pkg.sv
fb_bus_pkg.sv
vga_timing.sv
fb_fetch.sv
pixel_buffer.sv
vga_fb_top.sv
vga_fb_sva.sv
tb_vga_fb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_vga_fb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
